//--- Makefile
TB_TOP = tb_exec_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module exec_core

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) > sim.log 2>&1 ; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- alu_path.sv
`timescale 1ns/100ps

module alu_path (
  input  core_pkg::decoded_t   i_dec,
  output riscv_isa_pkg::word_t o_alu_res
);

  localparam int SHAMT_W = $clog2(riscv_isa_pkg::XLEN);

  riscv_isa_pkg::word_t src1;
  riscv_isa_pkg::word_t src2;
  core_pkg::alu_op_t alu_op;
  logic [SHAMT_W-1:0] shamt;

  // Operand select
  always_comb begin
    case (i_dec.opcode)
      riscv_isa_pkg::OPCODE_LUI:
        src1 = '0;
      riscv_isa_pkg::OPCODE_AUIPC:
        src1 = i_dec.pc;
      default:
        src1 = i_dec.rs1_data;
    endcase
    if (i_dec.opcode == riscv_isa_pkg::OPCODE_OP) begin
      src2 = i_dec.rs2_data;
    end else begin
      src2 = i_dec.imm;
    end
  end

  // Plain add for everything but OP and OP_IMM
  always_comb begin
    alu_op.op = riscv_isa_pkg::FUNCT3_ADD;
    alu_op.alt = 1'b0;
    if (i_dec.opcode == riscv_isa_pkg::OPCODE_OP) begin
      alu_op.op = i_dec.funct3;
      alu_op.alt = i_dec.alternate;
    end else if (i_dec.opcode == riscv_isa_pkg::OPCODE_OP_IMM) begin
      alu_op.op = i_dec.funct3;
      // Bit 30 is immediate data except on shifts right
      alu_op.alt = (i_dec.funct3 == riscv_isa_pkg::FUNCT3_SRA) & i_dec.alternate;
    end
  end

  assign shamt = src2[SHAMT_W-1:0];

  always_comb begin
    case (alu_op.op)
      riscv_isa_pkg::FUNCT3_ADD:
        o_alu_res = alu_op.alt ? src1 - src2 : src1 + src2;
      riscv_isa_pkg::FUNCT3_SLL:
        o_alu_res = src1 << shamt;
      riscv_isa_pkg::FUNCT3_SLT:
        o_alu_res = {{(riscv_isa_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      riscv_isa_pkg::FUNCT3_SLTU:
        o_alu_res = {{(riscv_isa_pkg::XLEN-1){1'b0}}, src1 < src2};
      riscv_isa_pkg::FUNCT3_XOR:
        o_alu_res = src1 ^ src2;
      riscv_isa_pkg::FUNCT3_SRA: begin
        if (alu_op.alt) begin
          o_alu_res = riscv_isa_pkg::word_t'($signed(src1) >>> shamt);
        end else begin
          o_alu_res = src1 >> shamt;
        end
      end
      riscv_isa_pkg::FUNCT3_OR:
        o_alu_res = src1 | src2;
      default:
        o_alu_res = src1 & src2;
    endcase
  end

endmodule

//--- branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
  input  core_pkg::decoded_t   i_dec,
  output logic                 o_taken,
  output riscv_isa_pkg::word_t o_npc
);

  logic cond;
  riscv_isa_pkg::word_t jalr_sum;

  always_comb begin
    case (i_dec.funct3)
      riscv_isa_pkg::FUNCT3_BEQ:  cond = i_dec.rs1_data == i_dec.rs2_data;
      riscv_isa_pkg::FUNCT3_BNE:  cond = i_dec.rs1_data != i_dec.rs2_data;
      riscv_isa_pkg::FUNCT3_BLT:  cond = $signed(i_dec.rs1_data) < $signed(i_dec.rs2_data);
      riscv_isa_pkg::FUNCT3_BGE:  cond = $signed(i_dec.rs1_data) >= $signed(i_dec.rs2_data);
      riscv_isa_pkg::FUNCT3_BLTU: cond = i_dec.rs1_data < i_dec.rs2_data;
      riscv_isa_pkg::FUNCT3_BGEU: cond = i_dec.rs1_data >= i_dec.rs2_data;
      default:                    cond = 1'b0;
    endcase
  end

  assign o_taken = (i_dec.opcode == riscv_isa_pkg::OPCODE_BRANCH) & cond;
  assign jalr_sum = i_dec.rs1_data + i_dec.imm;

  always_comb begin
    if (i_dec.opcode == riscv_isa_pkg::OPCODE_JAL || o_taken) begin
      o_npc = i_dec.pc + i_dec.imm;
    end else if (i_dec.opcode == riscv_isa_pkg::OPCODE_JALR) begin
      // Target LSB is dropped
      o_npc = {jalr_sum[riscv_isa_pkg::XLEN-1:1], 1'b0};
    end else begin
      o_npc = i_dec.pc + 'd4;
    end
    // An odd PC could only come from a bad immediate or reset vector
    if (i_dec.valid) begin
      assert (o_npc[0] == 1'b0);
    end
  end

endmodule

//--- commit_stage.sv
`timescale 1ns/100ps

module commit_stage #(
  parameter riscv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     nrst,
  input  core_pkg::decoded_t       i_dec,
  input  riscv_isa_pkg::word_t     i_alu_res,
  input  riscv_isa_pkg::word_t     i_npc,
  output riscv_isa_pkg::word_t     o_fetch_pc,
  output logic                     o_bypass_valid,
  output riscv_isa_pkg::reg_addr_t o_bypass_addr,
  output riscv_isa_pkg::word_t     o_bypass_data,
  output logic                     o_commit_valid,
  output core_pkg::commit_t        o_commit
);

  core_pkg::commit_t rec;
  riscv_isa_pkg::word_t pc_q;
  logic is_link;

  assign is_link = (i_dec.opcode == riscv_isa_pkg::OPCODE_JAL) ||
                   (i_dec.opcode == riscv_isa_pkg::OPCODE_JALR);

  always_comb begin
    rec.pc = i_dec.pc;
    rec.npc = i_npc;
    rec.inst = i_dec.inst;
    rec.rd_addr = i_dec.rd_addr;
    rec.rd_wb = i_dec.rd_wb & ~i_dec.illegal;
    // Link value for jumps
    rec.rd_data = is_link ? i_dec.pc + 'd4 : i_alu_res;
    rec.illegal = i_dec.illegal;
  end

  assign o_bypass_valid = i_dec.valid & rec.rd_wb;
  assign o_bypass_addr = rec.rd_addr;
  assign o_bypass_data = rec.rd_data;

  // Next instruction follows the one in decode, if any
  assign o_fetch_pc = i_dec.valid ? i_npc : pc_q;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pc_q <= RESET_PC;
      o_commit_valid <= 1'b0;
    end else begin
      if (i_dec.valid) begin
        pc_q <= i_npc;
      end
      o_commit_valid <= i_dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_dec.valid) begin
      o_commit <= rec;
    end
  end

endmodule

//--- core_pkg.sv
package core_pkg;

  // Operation as seen by the ALU
  typedef struct packed {
    riscv_isa_pkg::funct3_t op;
    logic alt;
  } alu_op_t;

  // Decode stage record
  typedef struct packed {
    riscv_isa_pkg::word_t pc;
    riscv_isa_pkg::word_t inst;
    riscv_isa_pkg::opcode_t opcode;
    riscv_isa_pkg::funct3_t funct3;
    logic alternate;
    riscv_isa_pkg::word_t imm;
    riscv_isa_pkg::word_t rs1_data;
    riscv_isa_pkg::word_t rs2_data;
    riscv_isa_pkg::reg_addr_t rd_addr;
    logic rd_wb;
    logic illegal;
    logic valid;
  } decoded_t;

  // Commit record, also the register file write port
  typedef struct packed {
    riscv_isa_pkg::word_t pc;
    riscv_isa_pkg::word_t npc;
    riscv_isa_pkg::word_t inst;
    riscv_isa_pkg::reg_addr_t rd_addr;
    logic rd_wb;
    riscv_isa_pkg::word_t rd_data;
    logic illegal;
  } commit_t;

endpackage

//--- exec_core.sv
`timescale 1ns/100ps

module exec_core #(
  parameter riscv_isa_pkg::word_t RESET_PC = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 i_inst_valid,
  input  riscv_isa_pkg::word_t i_inst,
  output logic                 o_commit_valid,
  output core_pkg::commit_t    o_commit
);

  riscv_isa_pkg::reg_addr_t rs1_addr;
  riscv_isa_pkg::reg_addr_t rs2_addr;
  riscv_isa_pkg::word_t rs1_data;
  riscv_isa_pkg::word_t rs2_data;
  riscv_isa_pkg::word_t fetch_pc;
  core_pkg::decoded_t dec;
  riscv_isa_pkg::word_t alu_res;
  riscv_isa_pkg::word_t npc;
  logic br_taken;
  logic byp_valid;
  riscv_isa_pkg::reg_addr_t byp_addr;
  riscv_isa_pkg::word_t byp_data;

  inst_decoder u_dec (
    .clk(clk), .nrst(nrst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .i_fetch_pc(fetch_pc),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_dec(dec)
  );

  reg_file u_rf (
    .clk(clk), .nrst(nrst),
    .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .i_bypass_valid(byp_valid), .i_bypass_addr(byp_addr), .i_bypass_data(byp_data),
    .i_wr_valid(o_commit_valid), .i_wr(o_commit),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  alu_path u_alu (.i_dec(dec), .o_alu_res(alu_res));

  branch_unit u_br (.i_dec(dec), .o_taken(br_taken), .o_npc(npc));

  commit_stage #(.RESET_PC(RESET_PC)) u_commit (
    .clk(clk), .nrst(nrst),
    .i_dec(dec), .i_alu_res(alu_res), .i_npc(npc),
    .o_fetch_pc(fetch_pc),
    .o_bypass_valid(byp_valid), .o_bypass_addr(byp_addr), .o_bypass_data(byp_data),
    .o_commit_valid(o_commit_valid), .o_commit(o_commit)
  );

  // Taken branch shows up on the commit port with its target one cycle later
  assert property (@(posedge clk) disable iff (!nrst)
    dec.valid && br_taken |=> o_commit_valid && o_commit.npc == $past(dec.pc + dec.imm));

endmodule

//--- inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     i_inst_valid,
  input  riscv_isa_pkg::word_t     i_inst,
  input  riscv_isa_pkg::word_t     i_fetch_pc,
  input  riscv_isa_pkg::word_t     i_rs1_data,
  input  riscv_isa_pkg::word_t     i_rs2_data,
  output riscv_isa_pkg::reg_addr_t o_rs1_addr,
  output riscv_isa_pkg::reg_addr_t o_rs2_addr,
  output core_pkg::decoded_t       o_dec
);

  riscv_isa_pkg::opcode_t opcode;
  riscv_isa_pkg::reg_addr_t rd_addr;
  riscv_isa_pkg::word_t imm;
  logic known_op;
  logic writes_rd;
  core_pkg::decoded_t dec_d;

  assign opcode = i_inst[riscv_isa_pkg::OPCODE_MSB:riscv_isa_pkg::OPCODE_LSB];
  assign rd_addr = i_inst[riscv_isa_pkg::RD_MSB:riscv_isa_pkg::RD_LSB];
  assign o_rs1_addr = i_inst[riscv_isa_pkg::RS1_MSB:riscv_isa_pkg::RS1_LSB];
  assign o_rs2_addr = i_inst[riscv_isa_pkg::RS2_MSB:riscv_isa_pkg::RS2_LSB];

  // I form unless the opcode says otherwise
  always_comb begin
    case (opcode)
      riscv_isa_pkg::OPCODE_LUI,
      riscv_isa_pkg::OPCODE_AUIPC:
        imm = {i_inst[31:12], 12'h000};
      riscv_isa_pkg::OPCODE_JAL:
        imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      riscv_isa_pkg::OPCODE_BRANCH:
        imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      default:
        imm = {{20{i_inst[31]}}, i_inst[31:20]};
    endcase
  end

  always_comb begin
    case (opcode)
      riscv_isa_pkg::OPCODE_OP,
      riscv_isa_pkg::OPCODE_OP_IMM,
      riscv_isa_pkg::OPCODE_LUI,
      riscv_isa_pkg::OPCODE_AUIPC,
      riscv_isa_pkg::OPCODE_JAL,
      riscv_isa_pkg::OPCODE_JALR: begin
        known_op = 1'b1;
        writes_rd = 1'b1;
      end
      riscv_isa_pkg::OPCODE_BRANCH: begin
        known_op = 1'b1;
        writes_rd = 1'b0;
      end
      default: begin
        known_op = 1'b0;
        writes_rd = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_d.pc = i_fetch_pc;
    dec_d.inst = i_inst;
    dec_d.opcode = opcode;
    dec_d.funct3 = i_inst[riscv_isa_pkg::FUNCT3_MSB:riscv_isa_pkg::FUNCT3_LSB];
    dec_d.alternate = i_inst[riscv_isa_pkg::ALT_BIT];
    dec_d.imm = imm;
    dec_d.rs1_data = i_rs1_data;
    dec_d.rs2_data = i_rs2_data;
    dec_d.rd_addr = rd_addr;
    // x0 is never a destination
    dec_d.rd_wb = writes_rd & (rd_addr != '0);
    dec_d.illegal = ~known_op;
    dec_d.valid = i_inst_valid;
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_dec.valid <= 1'b0;
    end else begin
      o_dec <= dec_d;
    end
  end

  // Accepted instruction never carries a write to x0 into decode
  assert property (@(posedge clk) disable iff (!nrst)
    i_inst_valid |=> !(o_dec.rd_wb && o_dec.rd_addr == '0));

endmodule

//--- project.f
riscv_isa_pkg.sv
core_pkg.sv
inst_decoder.sv
reg_file.sv
alu_path.sv
branch_unit.sv
commit_stage.sv
exec_core.sv
tb_exec_core.sv

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                     clk,
  input  logic                     nrst,
  input  riscv_isa_pkg::reg_addr_t i_rs1_addr,
  input  riscv_isa_pkg::reg_addr_t i_rs2_addr,
  input  logic                     i_bypass_valid,
  input  riscv_isa_pkg::reg_addr_t i_bypass_addr,
  input  riscv_isa_pkg::word_t     i_bypass_data,
  input  logic                     i_wr_valid,
  input  core_pkg::commit_t        i_wr,
  output riscv_isa_pkg::word_t     o_rs1_data,
  output riscv_isa_pkg::word_t     o_rs2_data
);

  localparam int NREGS = 32;

  riscv_isa_pkg::word_t regs [1:NREGS-1];
  logic wr_en;

  assign wr_en = i_wr_valid & i_wr.rd_wb;

  // Youngest result wins, then the commit record, then the array
  function automatic riscv_isa_pkg::word_t read_port(input riscv_isa_pkg::reg_addr_t addr);
    riscv_isa_pkg::word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (i_bypass_valid && i_bypass_addr == addr) begin
      data = i_bypass_data;
    end else if (wr_en && i_wr.rd_addr == addr) begin
      data = i_wr.rd_data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wr.rd_addr] <= i_wr.rd_data;
    end
  end

  // Decode and commit together must keep x0 out of the write port
  assert property (@(posedge clk) disable iff (!nrst)
    wr_en |-> i_wr.rd_addr != '0);

endmodule

//--- riscv_isa_pkg.sv
package riscv_isa_pkg;

  localparam int XLEN = 32;

  // Instruction field positions
  localparam int OPCODE_LSB = 2;
  localparam int OPCODE_MSB = 6;
  localparam int RD_LSB = 7;
  localparam int RD_MSB = 11;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_MSB = 14;
  localparam int RS1_LSB = 15;
  localparam int RS1_MSB = 19;
  localparam int RS2_LSB = 20;
  localparam int RS2_MSB = 24;
  localparam int ALT_BIT = 30;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [4:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Major opcodes, bits 6 to 2
  localparam opcode_t OPCODE_OP_IMM = 5'b00100;
  localparam opcode_t OPCODE_AUIPC = 5'b00101;
  localparam opcode_t OPCODE_OP = 5'b01100;
  localparam opcode_t OPCODE_LUI = 5'b01101;
  localparam opcode_t OPCODE_BRANCH = 5'b11000;
  localparam opcode_t OPCODE_JALR = 5'b11001;
  localparam opcode_t OPCODE_JAL = 5'b11011;

  // ALU minor codes
  localparam funct3_t FUNCT3_ADD = 3'b000;
  localparam funct3_t FUNCT3_SLL = 3'b001;
  localparam funct3_t FUNCT3_SLT = 3'b010;
  localparam funct3_t FUNCT3_SLTU = 3'b011;
  localparam funct3_t FUNCT3_XOR = 3'b100;
  localparam funct3_t FUNCT3_SRA = 3'b101;
  localparam funct3_t FUNCT3_OR = 3'b110;
  localparam funct3_t FUNCT3_AND = 3'b111;

  // Branch conditions
  localparam funct3_t FUNCT3_BEQ = 3'b000;
  localparam funct3_t FUNCT3_BNE = 3'b001;
  localparam funct3_t FUNCT3_BLT = 3'b100;
  localparam funct3_t FUNCT3_BGE = 3'b101;
  localparam funct3_t FUNCT3_BLTU = 3'b110;
  localparam funct3_t FUNCT3_BGEU = 3'b111;

endpackage

//--- tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;

  localparam riscv_isa_pkg::word_t RESET_PC = 32'h0000_1000;
  localparam int WAIT_LIMIT = 20;

  logic clk;
  logic nrst;
  logic i_inst_valid;
  riscv_isa_pkg::word_t i_inst;
  logic o_commit_valid;
  core_pkg::commit_t o_commit;

  // Architectural state of the reference model
  riscv_isa_pkg::word_t mregs [0:31];
  riscv_isa_pkg::word_t mpc;
  core_pkg::commit_t exp_q [$];
  int errors;
  int checks;
  int seed;

  exec_core #(.RESET_PC(RESET_PC)) dut0 (
    .clk(clk), .nrst(nrst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_commit_valid(o_commit_valid), .o_commit(o_commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic riscv_isa_pkg::word_t enc_r(input logic [6:0] f7, input int rs2,
      input int rs1, input riscv_isa_pkg::funct3_t f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), riscv_isa_pkg::OPCODE_OP, 2'b11};
  endfunction

  function automatic riscv_isa_pkg::word_t enc_i(input riscv_isa_pkg::opcode_t opc,
      input int imm, input int rs1, input riscv_isa_pkg::funct3_t f3, input int rd);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc, 2'b11};
  endfunction

  function automatic riscv_isa_pkg::word_t enc_u(input riscv_isa_pkg::opcode_t opc,
      input logic [19:0] upper, input int rd);
    return {upper, 5'(rd), opc, 2'b11};
  endfunction

  function automatic riscv_isa_pkg::word_t enc_j(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), riscv_isa_pkg::OPCODE_JAL, 2'b11};
  endfunction

  function automatic riscv_isa_pkg::word_t enc_b(input riscv_isa_pkg::funct3_t f3,
      input int rs1, input int rs2, input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11],
            riscv_isa_pkg::OPCODE_BRANCH, 2'b11};
  endfunction

  function automatic riscv_isa_pkg::word_t alu_ref(input riscv_isa_pkg::funct3_t f3,
      input logic alt, input riscv_isa_pkg::word_t a, input riscv_isa_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? riscv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input riscv_isa_pkg::funct3_t f3,
      input riscv_isa_pkg::word_t a, input riscv_isa_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Executes one instruction on the model and returns its commit record
  function automatic core_pkg::commit_t model_step(input riscv_isa_pkg::word_t inst);
    core_pkg::commit_t c;
    riscv_isa_pkg::word_t a;
    riscv_isa_pkg::word_t b;
    riscv_isa_pkg::word_t imm_i;
    logic writes;
    a = mregs[inst[19:15]];
    b = mregs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    writes = 1'b1;
    c.pc = mpc;
    c.npc = mpc + 4;
    c.inst = inst;
    c.rd_addr = inst[11:7];
    c.rd_data = '0;
    c.illegal = 1'b0;
    case (inst[6:2])
      riscv_isa_pkg::OPCODE_OP:
        c.rd_data = alu_ref(inst[14:12], inst[30], a, b);
      riscv_isa_pkg::OPCODE_OP_IMM:
        c.rd_data = alu_ref(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, imm_i);
      riscv_isa_pkg::OPCODE_LUI:
        c.rd_data = {inst[31:12], 12'h000};
      riscv_isa_pkg::OPCODE_AUIPC:
        c.rd_data = mpc + {inst[31:12], 12'h000};
      riscv_isa_pkg::OPCODE_JAL: begin
        c.rd_data = mpc + 4;
        c.npc = mpc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      riscv_isa_pkg::OPCODE_JALR: begin
        c.rd_data = mpc + 4;
        c.npc = (a + imm_i) & ~32'd1;
      end
      riscv_isa_pkg::OPCODE_BRANCH: begin
        writes = 1'b0;
        if (branch_ref(inst[14:12], a, b)) begin
          c.npc = mpc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: begin
        writes = 1'b0;
        c.illegal = 1'b1;
      end
    endcase
    c.rd_wb = writes && c.rd_addr != 5'd0;
    if (c.rd_wb) begin
      mregs[c.rd_addr] = c.rd_data;
    end
    mpc = c.npc;
    return c;
  endfunction

  task automatic report_field(input string name, input riscv_isa_pkg::word_t got,
      input riscv_isa_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // rd_data has no meaning when nothing is written back
  task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
    checks++;
    report_field("o_commit.pc", got.pc, exp.pc);
    report_field("o_commit.npc", got.npc, exp.npc);
    report_field("o_commit.inst", got.inst, exp.inst);
    report_field("o_commit.rd_addr", 32'(got.rd_addr), 32'(exp.rd_addr));
    report_field("o_commit.rd_wb", 32'(got.rd_wb), 32'(exp.rd_wb));
    report_field("o_commit.illegal", 32'(got.illegal), 32'(exp.illegal));
    if (exp.rd_wb) begin
      report_field("o_commit.rd_data", got.rd_data, exp.rd_data);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t o_commit_valid got %b exp %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic end_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Commit port watcher, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (nrst && o_commit_valid) begin
      if (exp_q.size() == 0) begin
        $display("A commit appeared at %0t with no instruction outstanding", $time);
        errors++;
      end else begin
        check_commit(o_commit, exp_q.pop_front());
      end
    end
  end

  task automatic send_inst(input riscv_isa_pkg::word_t inst);
    i_inst_valid = 1'b1;
    i_inst = inst;
    exp_q.push_back(model_step(inst));
    @(negedge clk);
    i_inst_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drain_commits();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: no commit came for %0d sent instructions", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (6) begin
      check_valid(o_commit_valid, 1'b0);
      @(negedge clk);
    end
    // Model PC starts at RESET_PC
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 5, 0, riscv_isa_pkg::FUNCT3_ADD, 1));
    drain_commits();
    report_test("reset", e0);
  endtask

  task automatic test_imm();
    int e0;
    e0 = errors;
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -7, 0, riscv_isa_pkg::FUNCT3_ADD, 2));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 100, 2, riscv_isa_pkg::FUNCT3_ADD, 3));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -3, 2, riscv_isa_pkg::FUNCT3_SLT, 4));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 5, 2, riscv_isa_pkg::FUNCT3_SLTU, 5));
    idle_cycles(2);
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -1, 2, riscv_isa_pkg::FUNCT3_XOR, 6));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 4, 2, riscv_isa_pkg::FUNCT3_SLL, 7));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 'h402, 2, riscv_isa_pkg::FUNCT3_SRA, 8));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 3, 2, riscv_isa_pkg::FUNCT3_SRA, 9));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -256, 3, riscv_isa_pkg::FUNCT3_OR, 10));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -16, 10, riscv_isa_pkg::FUNCT3_AND, 11));
    send_inst(enc_u(riscv_isa_pkg::OPCODE_LUI, 20'habcde, 12));
    send_inst(enc_u(riscv_isa_pkg::OPCODE_AUIPC, 20'hfffff, 13));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 1, 2, riscv_isa_pkg::FUNCT3_ADD, 0));
    drain_commits();
    report_test("immediates", e0);
  endtask

  task automatic test_bypass();
    int e0;
    e0 = errors;
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 37, 0, riscv_isa_pkg::FUNCT3_ADD, 1));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -12, 0, riscv_isa_pkg::FUNCT3_ADD, 2));
    drain_commits();
    // Each one reads a result that is not yet in the array
    send_inst(enc_r(7'h00, 2, 1, riscv_isa_pkg::FUNCT3_ADD, 3));
    send_inst(enc_r(7'h20, 1, 3, riscv_isa_pkg::FUNCT3_ADD, 4));
    send_inst(enc_r(7'h00, 0, 4, riscv_isa_pkg::FUNCT3_SLT, 5));
    send_inst(enc_r(7'h00, 1, 4, riscv_isa_pkg::FUNCT3_SLTU, 6));
    send_inst(enc_r(7'h20, 6, 2, riscv_isa_pkg::FUNCT3_SRA, 7));
    send_inst(enc_r(7'h00, 1, 7, riscv_isa_pkg::FUNCT3_AND, 8));
    // x10 comes from the commit record, x11 from the forming record
    send_inst(enc_r(7'h00, 1, 1, riscv_isa_pkg::FUNCT3_ADD, 10));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 3, 0, riscv_isa_pkg::FUNCT3_ADD, 11));
    send_inst(enc_r(7'h20, 11, 10, riscv_isa_pkg::FUNCT3_ADD, 12));
    idle_cycles(3);
    send_inst(enc_r(7'h00, 10, 12, riscv_isa_pkg::FUNCT3_ADD, 14));
    idle_cycles(1);
    send_inst(enc_r(7'h20, 8, 14, riscv_isa_pkg::FUNCT3_ADD, 15));
    drain_commits();
    report_test("bypass", e0);
  endtask

  task automatic test_branches();
    int e0;
    e0 = errors;
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 5, 0, riscv_isa_pkg::FUNCT3_ADD, 1));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, -3, 0, riscv_isa_pkg::FUNCT3_ADD, 2));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BEQ, 1, 1, 16));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BEQ, 1, 2, 16));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BNE, 1, 2, -8));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BNE, 2, 2, -8));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BLT, 2, 1, 40));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BLT, 1, 2, 40));
    idle_cycles(2);
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BGE, 1, 2, -100));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BGE, 2, 1, -100));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BLTU, 1, 2, 2048));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BLTU, 2, 1, 2048));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BGEU, 2, 1, -4096));
    send_inst(enc_b(riscv_isa_pkg::FUNCT3_BGEU, 1, 2, -4096));
    drain_commits();
    report_test("branches", e0);
  endtask

  task automatic test_jumps();
    int e0;
    e0 = errors;
    send_inst(enc_j(64, 1));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_JALR, 3, 1, 3'd0, 5));
    send_inst(enc_j(-32, 0));
    send_inst(enc_i(riscv_isa_pkg::OPCODE_OP_IMM, 0, 5, riscv_isa_pkg::FUNCT3_ADD, 2));
    // Load opcode is outside the core and must leave x2 alone
    send_inst(enc_i(5'b00000, 4, 0, 3'd0, 2));
    send_inst(enc_r(7'h00, 0, 2, riscv_isa_pkg::FUNCT3_ADD, 3));
    idle_cycles(3);
    send_inst(enc_r(7'h00, 0, 2, riscv_isa_pkg::FUNCT3_ADD, 4));
    drain_commits();
    report_test("jumps", e0);
  endtask

  task automatic test_random();
    int e0;
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    riscv_isa_pkg::funct3_t f3;
    logic [6:0] f7;
    riscv_isa_pkg::word_t inst;
    e0 = errors;
    for (int n = 0; n < 200; n++) begin
      kind = $unsigned($random(seed)) % 3;
      f3 = 3'($random(seed));
      rd = $unsigned($random(seed)) % 8;
      rs1 = $unsigned($random(seed)) % 8;
      rs2 = $unsigned($random(seed)) % 8;
      imm = $random(seed);
      if (kind == 0) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[20]) ? 7'h20 : 7'h00;
        inst = enc_r(f7, rs2, rs1, f3, rd);
      end else if (kind == 1) begin
        if (f3 == 3'd1) begin
          imm = imm & 'h1f;
        end else if (f3 == 3'd5) begin
          imm = imm & 'h41f;
        end
        inst = enc_i(riscv_isa_pkg::OPCODE_OP_IMM, imm, rs1, f3, rd);
      end else begin
        inst = enc_u(riscv_isa_pkg::OPCODE_LUI, 20'(imm), rd);
      end
      send_inst(inst);
      idle_cycles($unsigned($random(seed)) % 3);
    end
    drain_commits();
    report_test("random", e0);
  endtask

  initial begin
    seed = 27482;
    errors = 0;
    checks = 0;
    nrst = 1'b0;
    i_inst_valid = 1'b0;
    i_inst = '0;
    mpc = RESET_PC;
    for (int r = 0; r < 32; r++) begin
      mregs[r] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
    test_reset();
    test_imm();
    test_bypass();
    test_branches();
    test_jumps();
    test_random();
    end_run();
  end

endmodule
